/* vlog.f */
hw/mac_pkg.sv
hw/packet_ring.sv
hw/host_port.sv
hw/gmii_tx.sv
hw/gmii_rx.sv
hw/packet_mac.sv
verification/tb_packet_mac.sv

/* run.sh */
#!/bin/sh
# build and run the packet_mac testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_packet_mac \
    -f vlog.f \
    --Mdir obj_dir \
    -o sim_packet_mac
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_packet_mac > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* verification/tb_packet_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_packet_mac import mac_pkg::*;;

    localparam int ring_depth  = 4;
    localparam int packet_size = 64;
    localparam int aw          = $clog2(packet_size);
    localparam int cycle_limit = 20000; // roughly ten times the longest test

    logic      clock;
    logic      reset;
    logic      op_start;
    host_req_t op_req;
    logic      op_done;
    pkt_addr_t op_result;
    gmii_tx_t  gmii_tx;
    gmii_rx_t  gmii_rx;

    integer seed;
    int     cycle_count;

    // reference model
    byte_t fill_buf [packet_size];
    int    fill_len_m;
    byte_t tx_exp_data[$]; // committed tx frames, back to back
    int    tx_exp_len[$];
    byte_t rx_exp_data[$]; // accepted rx frames, back to back
    int    rx_exp_len[$];

    // tx monitor state
    byte_t tx_wire[$];
    int    low_run;
    logic  seen_frame;

    packet_mac #(.ring_depth(ring_depth), .packet_size(packet_size)) packet_mac_i (
        .clock     (clock),
        .reset     (reset),
        .op_start  (op_start),
        .op_req    (op_req),
        .op_done   (op_done),
        .op_result (op_result),
        .gmii_tx   (gmii_tx),
        .gmii_rx   (gmii_rx)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("ERROR: the run did not finish within %0d clock cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("MISMATCH at %0t ns: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic int pick(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // bitwise reflected crc-32
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input byte_t b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hedb8_8320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic run_op(input mac_op_e op, input int addr, input int value,
                          output int result);
        int waited;
        op_req.op      = op;
        op_req.address = pkt_addr_t'(addr);
        op_req.value   = byte_t'(value);
        op_start       = 1'b1;
        @(negedge clock);
        op_start = 1'b0;
        waited   = 1;
        while (!op_done && waited < 8) begin
            @(negedge clock);
            waited++;
        end
        if (!op_done) begin
            $display("ERROR: op_done never came for %s", op.name());
            $display("Simulation failed");
            $fatal(1, "host operation hung");
        end
        check(waited, 2, "cycles from op_start to op_done");
        result = int'(op_result);
    endtask

    // ------------------------------------------------------------
    // transmit side
    // ------------------------------------------------------------
    task automatic host_write(input int addr, input int value);
        int res;
        run_op(op_write, addr, value, res);
        if (addr < packet_size) begin
            fill_buf[aw'(addr)] = byte_t'(value);
            if (addr + 1 > fill_len_m) begin
                fill_len_m = addr + 1;
            end
        end
        check(res, int'(addr >= packet_size), $sformatf("write result at address %0d", addr));
    endtask

    task automatic check_write_len();
        int res;
        run_op(op_write_len, 0, 0, res);
        check(res, fill_len_m, "write_len");
    endtask

    task automatic commit_tx();
        int res;
        int full;
        full = int'(tx_exp_len.size() >= ring_depth - 1);
        run_op(op_write_next, 0, 0, res);
        check(res, full, "write_next result");
        if (full == 0) begin
            for (int i = 0; i < fill_len_m; i++) begin
                tx_exp_data.push_back(fill_buf[aw'(i)]);
            end
            tx_exp_len.push_back(fill_len_m);
            fill_len_m = 0;
        end
    endtask

    // every address below len gets written so no stale slot byte is sent
    task automatic fill_tx_frame(input int len);
        int   addr;
        logic down;
        down = (pick(0, 1) == 1);
        for (int i = 0; i < len; i++) begin
            addr = down ? len - 1 - i : i;
            host_write(addr, pick(0, 255));
            if (pick(0, 3) == 0) begin
                host_write(packet_size + pick(0, 400), pick(0, 255)); // out of range
            end
            if (pick(0, 7) == 0) begin
                check_write_len();
            end
        end
        repeat (pick(0, 3)) host_write(pick(0, len - 1), pick(0, 255));
        check_write_len();
    endtask

    task automatic check_tx_frame();
        byte_t       exp_bytes[$];
        logic [31:0] crc;
        int          len;
        check(int'(tx_exp_len.size() != 0), 1, "frame on gmii_tx with nothing committed");
        len = tx_exp_len.pop_front();
        for (int i = 0; i < 7; i++) begin
            exp_bytes.push_back(8'h55);
        end
        exp_bytes.push_back(8'hd5);
        crc = 32'hffff_ffff;
        for (int i = 0; i < len; i++) begin
            exp_bytes.push_back(tx_exp_data[0]);
            crc = crc_byte(crc, tx_exp_data[0]);
            tx_exp_data.delete(0);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(crc[8*i +: 8]); // lsb byte first
        end
        check(tx_wire.size(), exp_bytes.size(), "cycles with tx en high");
        for (int i = 0; i < exp_bytes.size(); i++) begin
            check(int'(tx_wire[i]), int'(exp_bytes[i]), $sformatf("tx byte %0d", i));
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            low_run    = 0;
            seen_frame = 1'b0;
            tx_wire.delete();
        end else begin
            check(int'(gmii_tx.er), 0, "tx er");
            if (gmii_tx.en) begin
                if (tx_wire.size() == 0 && seen_frame) begin
                    check(int'(low_run >= 12), 1, "low cycles between tx frames");
                end
                tx_wire.push_back(gmii_tx.data);
                low_run = 0;
            end else begin
                if (tx_wire.size() != 0) begin
                    check_tx_frame();
                    tx_wire.delete();
                    seen_frame = 1'b1;
                end
                low_run++;
            end
        end
    end

    task automatic wait_tx_idle();
        while (tx_exp_len.size() != 0) @(negedge clock);
        repeat (4) @(negedge clock);
    endtask

    // ------------------------------------------------------------
    // receive side
    // ------------------------------------------------------------
    // kind 0..2 good, 3 bad fcs, 4 rx er, 5 bad start byte
    task automatic send_rx_frame(input int kind, input int len);
        byte_t       stream[$];
        byte_t       data[$];
        byte_t       b;
        logic [31:0] crc;
        logic [31:0] fcs;
        int          err_at;
        for (int i = 0; i < 7; i++) begin
            stream.push_back(8'h55);
        end
        stream.push_back(kind == 5 ? 8'h5d : 8'hd5);
        crc = 32'hffff_ffff;
        for (int i = 0; i < len; i++) begin
            b = byte_t'(pick(0, 255));
            data.push_back(b);
            stream.push_back(b);
            crc = crc_byte(crc, b);
        end
        fcs = ~crc;
        if (kind == 3) begin
            fcs = fcs ^ (32'h1 << pick(0, 31)); // single bit flip
        end
        for (int i = 0; i < 4; i++) begin
            stream.push_back(fcs[8*i +: 8]);
        end
        err_at = (kind == 4) ? 8 + pick(0, len - 1) : -1;
        for (int i = 0; i < stream.size(); i++) begin
            gmii_rx.dv   = 1'b1;
            gmii_rx.data = stream[i];
            gmii_rx.er   = (i == err_at);
            @(negedge clock);
        end
        gmii_rx = '0;
        repeat (12) @(negedge clock);
        if (kind <= 2 && rx_exp_len.size() < ring_depth - 1) begin
            for (int i = 0; i < len; i++) begin
                rx_exp_data.push_back(data[i]);
            end
            rx_exp_len.push_back(len);
        end
    endtask

    task automatic check_rx_empty();
        int res;
        run_op(op_read_next, 0, 0, res);
        check(res, 1, "read_next on empty rx ring");
        run_op(op_read_len, 0, 0, res);
        check(res, 0, "read_len on empty rx ring");
    endtask

    task automatic drain_rx();
        int res;
        int len;
        while (rx_exp_len.size() != 0) begin
            len = rx_exp_len[0];
            run_op(op_read_len, 0, 0, res);
            check(res, len, "read_len");
            for (int a = 0; a < len; a++) begin
                run_op(op_read, a, 0, res);
                check(res, int'(rx_exp_data[a]), $sformatf("read at address %0d", a));
            end
            run_op(op_read, len, 0, res);
            check(res, 0, "read just past the length");
            run_op(op_read, pick(len, 400), 0, res);
            check(res, 0, "read beyond the length");
            run_op(op_read_next, 0, 0, res);
            check(res, 0, "read_next");
            for (int a = 0; a < len; a++) begin
                rx_exp_data.delete(0);
            end
            void'(rx_exp_len.pop_front());
        end
        check_rx_empty();
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed       = 32'hf4ce;
        fill_len_m = 0;
        reset      = 1'b1;
        op_start   = 1'b0;
        op_req     = '0;
        gmii_rx    = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (2) @(negedge clock);

        // ring fills up while the first long frame is still on the wire
        fill_tx_frame(packet_size);
        repeat (4) commit_tx();
        wait_tx_idle();

        for (int f = 0; f < 6; f++) begin
            fill_tx_frame(pick(1, packet_size));
            while (tx_exp_len.size() >= ring_depth - 1) @(negedge clock);
            commit_tx();
        end
        wait_tx_idle();

        check_rx_empty();
        for (int batch = 0; batch < 4; batch++) begin
            for (int k = 0; k < 5; k++) begin
                send_rx_frame(pick(0, 5), pick(1, packet_size));
            end
            drain_rx();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/packet_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_mac import mac_pkg::*; #(
    parameter int ring_depth  = default_ring_depth,
    parameter int packet_size = default_packet_size
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      op_start,
    input  host_req_t op_req,
    output logic      op_done,
    output pkt_addr_t op_result,
    output gmii_tx_t  gmii_tx,
    input  gmii_rx_t  gmii_rx
);

    fill_req_t  tx_fill;
    fill_req_t  rx_fill;
    drain_req_t tx_drain;
    drain_req_t rx_drain;
    logic       tx_full;
    logic       rx_full;
    logic       tx_valid;
    logic       rx_valid;
    pkt_addr_t  tx_len;
    pkt_addr_t  rx_len;
    byte_t      tx_byte;
    byte_t      rx_byte;

    // host fills, tx engine drains
    packet_ring #(.ring_depth(ring_depth), .packet_size(packet_size)) tx_ring (
        .clock       (clock),
        .reset       (reset),
        .fill        (tx_fill),
        .fill_full   (tx_full),
        .drain       (tx_drain),
        .drain_valid (tx_valid),
        .drain_len   (tx_len),
        .drain_data  (tx_byte)
    );

    // rx engine fills, host drains
    packet_ring #(.ring_depth(ring_depth), .packet_size(packet_size)) rx_ring (
        .clock       (clock),
        .reset       (reset),
        .fill        (rx_fill),
        .fill_full   (rx_full),
        .drain       (rx_drain),
        .drain_valid (rx_valid),
        .drain_len   (rx_len),
        .drain_data  (rx_byte)
    );

    host_port #(.packet_size(packet_size)) host_port_i (
        .clock     (clock),
        .reset     (reset),
        .op_start  (op_start),
        .op_req    (op_req),
        .op_done   (op_done),
        .op_result (op_result),
        .tx_fill   (tx_fill),
        .tx_full   (tx_full),
        .rx_drain  (rx_drain),
        .rx_valid  (rx_valid),
        .rx_len    (rx_len),
        .rx_data   (rx_byte)
    );

    gmii_tx #(.packet_size(packet_size)) gmii_tx_i (
        .clock       (clock),
        .reset       (reset),
        .drain_valid (tx_valid),
        .drain_len   (tx_len),
        .drain_data  (tx_byte),
        .drain       (tx_drain),
        .gmii_tx     (gmii_tx)
    );

    gmii_rx #(.packet_size(packet_size)) gmii_rx_i (
        .clock     (clock),
        .reset     (reset),
        .gmii_rx   (gmii_rx),
        .fill_full (rx_full),
        .fill      (rx_fill)
    );

endmodule

`default_nettype wire

/* hw/gmii_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module gmii_rx import mac_pkg::*; #(
    parameter int packet_size = default_packet_size
) (
    input  logic      clock,
    input  logic      reset,
    input  gmii_rx_t  gmii_rx,
    input  logic      fill_full,
    output fill_req_t fill
);

    localparam pkt_addr_t max_bytes = pkt_addr_t'(packet_size + 4); // data plus fcs

    rx_state_e   state;
    logic [2:0]  pre_cnt;  // preamble bytes seen
    pkt_addr_t   count;    // bytes stored, fcs included
    logic [31:0] crc;
    logic        err_seen;
    logic        commit_q;
    logic        frame_ok;

    assign frame_ok = (crc == crc_residue)
                   && (count >= 16'd4)
                   && (count <= max_bytes)
                   && !err_seen
                   && !fill_full;

    always_comb begin
        fill.write  = (state == rx_data) && gmii_rx.dv;
        fill.commit = commit_q;
        fill.addr   = count;
        fill.data   = gmii_rx.data;
        fill.len    = count - 16'd4; // strip fcs
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= rx_idle;
            pre_cnt  <= '0;
            count    <= '0;
            commit_q <= 1'b0;
        end else begin
            commit_q <= 1'b0;
            case (state)
                rx_idle: if (gmii_rx.dv) begin
                    if (!gmii_rx.er && gmii_rx.data == preamble_byte) begin
                        state   <= rx_preamble;
                        pre_cnt <= 3'd1;
                    end else begin
                        state <= rx_drop;
                    end
                end

                rx_preamble: begin
                    if (!gmii_rx.dv) begin
                        state <= rx_idle;
                    end else if (gmii_rx.er) begin
                        state <= rx_drop;
                    end else if (gmii_rx.data == preamble_byte
                                 && pre_cnt != 3'(preamble_len)) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end else if (gmii_rx.data == sfd_byte
                                 && pre_cnt == 3'(preamble_len)) begin
                        state    <= rx_data;
                        count    <= '0;
                        crc      <= crc_init;
                        err_seen <= 1'b0;
                    end else begin
                        state <= rx_drop;
                    end
                end

                rx_data: begin
                    if (gmii_rx.dv) begin
                        if (count <= max_bytes) begin
                            count <= count + 1'b1; // saturates one past max
                        end
                        crc <= next_crc32(gmii_rx.data, crc);
                        if (gmii_rx.er) begin
                            err_seen <= 1'b1;
                        end
                    end else begin
                        commit_q <= frame_ok; // dv fell, decide
                        state    <= rx_idle;
                    end
                end

                rx_drop: if (!gmii_rx.dv) begin
                    state <= rx_idle;
                end

                default: state <= rx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/gmii_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module gmii_tx import mac_pkg::*; #(
    parameter int packet_size = default_packet_size
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       drain_valid,
    input  pkt_addr_t  drain_len,
    input  byte_t      drain_data,
    output drain_req_t drain,
    output gmii_tx_t   gmii_tx
);

    tx_state_e   state;
    logic [3:0]  cnt;     // preamble, fcs and gap
    pkt_addr_t   rd_addr; // one ahead of the byte going out
    logic [31:0] crc;
    logic        last_fcs;

    assign last_fcs = (state == tx_fcs) && (cnt == 4'd3);

    always_comb begin
        drain.addr         = rd_addr;
        drain.release_slot = last_fcs;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= tx_idle;
            cnt     <= '0;
            gmii_tx <= '0;
        end else begin
            gmii_tx.er <= 1'b0;
            case (state)
                tx_idle: if (drain_valid) begin
                    state        <= tx_preamble;
                    cnt          <= '0;
                    rd_addr      <= '0;
                    crc          <= crc_init;
                    gmii_tx.en   <= 1'b1;
                    gmii_tx.data <= preamble_byte;
                end

                tx_preamble: begin
                    if (cnt == 4'(preamble_len - 1)) begin
                        state        <= tx_sfd;
                        gmii_tx.data <= sfd_byte;
                        rd_addr      <= 16'd1; // byte 0 already in drain_data
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                // rd_addr - 1 bytes are out in both states
                tx_sfd, tx_data: begin
                    if (rd_addr == drain_len + 16'd1) begin
                        state        <= tx_fcs;
                        cnt          <= '0;
                        gmii_tx.data <= ~crc[7:0];
                        crc          <= crc >> 8;
                    end else begin
                        state        <= tx_data;
                        gmii_tx.data <= drain_data;
                        crc          <= next_crc32(drain_data, crc);
                        rd_addr      <= rd_addr + 1'b1;
                    end
                end

                tx_fcs: begin
                    if (last_fcs) begin
                        state      <= tx_gap;
                        cnt        <= '0;
                        gmii_tx    <= '0;
                    end else begin
                        cnt          <= cnt + 1'b1;
                        gmii_tx.data <= ~crc[7:0]; // lsb byte first
                        crc          <= crc >> 8;
                    end
                end

                tx_gap: begin
                    if (cnt == 4'(ifg_cycles - 1)) begin
                        state <= tx_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                default: state <= tx_idle;
            endcase
        end
    end

    // slot lengths come from the host side of the ring
    a_len_fits : assert property (
        @(posedge clock) disable iff (reset)
        drain_valid |-> drain_len <= pkt_addr_t'(packet_size)
    ) else $error("gmii_tx: committed length larger than a slot");

endmodule

`default_nettype wire

/* hw/host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module host_port import mac_pkg::*; #(
    parameter int packet_size = default_packet_size
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       op_start,
    input  host_req_t  op_req,
    output logic       op_done,
    output pkt_addr_t  op_result,
    output fill_req_t  tx_fill,
    input  logic       tx_full,
    output drain_req_t rx_drain,
    input  logic       rx_valid,
    input  pkt_addr_t  rx_len,
    input  byte_t      rx_data
);

    logic      busy;     // stage 1, ring access cycle
    host_req_t req_q;
    pkt_addr_t fill_len; // bytes in the open tx slot
    pkt_addr_t res_q;
    logic      use_byte; // result comes from the rx byte
    logic      addr_ok;
    logic      in_range;
    logic      accept;

    assign accept   = op_start && !busy;
    assign addr_ok  = (req_q.address < pkt_addr_t'(packet_size));
    assign in_range = rx_valid && (req_q.address < rx_len);

    always_comb begin
        tx_fill.write  = busy && (req_q.op == op_write) && addr_ok;
        tx_fill.commit = busy && (req_q.op == op_write_next) && !tx_full;
        tx_fill.addr   = req_q.address;
        tx_fill.data   = req_q.value;
        tx_fill.len    = fill_len;

        rx_drain.addr         = req_q.address;
        rx_drain.release_slot = busy && (req_q.op == op_read_next) && rx_valid;
    end

    assign op_result = use_byte ? {8'h00, rx_data} : res_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            op_done  <= 1'b0;
            fill_len <= '0;
        end else begin
            busy    <= accept;
            op_done <= busy;
            if (tx_fill.write && req_q.address >= fill_len) begin
                fill_len <= req_q.address + 16'd1;
            end else if (tx_fill.commit) begin
                fill_len <= '0;
            end
        end
    end

    // stage 2 result, valid with op_done
    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= op_req;
        end
        use_byte <= 1'b0;
        res_q    <= '0;
        if (busy) begin
            case (req_q.op)
                op_read:       use_byte <= in_range;
                op_read_len:   res_q <= rx_valid ? rx_len : '0;
                op_read_next:  res_q <= pkt_addr_t'(!rx_valid);
                op_write:      res_q <= pkt_addr_t'(!addr_ok);
                op_write_len:  res_q <= fill_len;
                op_write_next: res_q <= pkt_addr_t'(tx_full);
                default:       ;
            endcase
        end
    end

    // host has to wait for op_done
    a_no_overlap : assert property (
        @(posedge clock) disable iff (reset) op_start |-> !busy
    ) else $error("host_port: op_start while an operation is in flight");

endmodule

`default_nettype wire

/* hw/packet_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_ring import mac_pkg::*; #(
    parameter int ring_depth  = default_ring_depth,
    parameter int packet_size = default_packet_size
) (
    input  logic       clock,
    input  logic       reset,
    input  fill_req_t  fill,
    output logic       fill_full,
    input  drain_req_t drain,
    output logic       drain_valid,
    output pkt_addr_t  drain_len,
    output byte_t      drain_data
);

    localparam int ptr_w = (ring_depth > 1) ? $clog2(ring_depth) : 1;
    localparam int aw    = (packet_size > 1) ? $clog2(packet_size) : 1;

    typedef logic [ptr_w-1:0] slot_t;

    byte_t     mem     [ring_depth][packet_size];
    pkt_addr_t len_tab [ring_depth];

    slot_t head;  // open fill slot
    slot_t tail;  // oldest committed slot
    slot_t count; // committed slots, never above ring_depth - 1

    assign fill_full   = (count == slot_t'(ring_depth - 1));
    assign drain_valid = (count != '0);
    assign drain_len   = len_tab[tail];

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (fill.commit) begin
                head <= (head == slot_t'(ring_depth - 1)) ? '0 : head + 1'b1;
            end
            if (drain.release_slot) begin
                tail <= (tail == slot_t'(ring_depth - 1)) ? '0 : tail + 1'b1;
            end
            case ({fill.commit, drain.release_slot})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (fill.write && fill.addr < pkt_addr_t'(packet_size)) begin
            mem[head][fill.addr[aw-1:0]] <= fill.data;
        end
        if (fill.commit) begin
            len_tab[head] <= fill.len;
        end
        drain_data <= mem[tail][drain.addr[aw-1:0]]; // one cycle read
    end

    // clients must look at full / valid before they strobe
    a_commit_has_room : assert property (
        @(posedge clock) disable iff (reset) fill.commit |-> !fill_full
    ) else $error("packet_ring: commit with no free slot");

    a_release_has_slot : assert property (
        @(posedge clock) disable iff (reset) drain.release_slot |-> drain_valid
    ) else $error("packet_ring: release on an empty ring");

endmodule

`default_nettype wire

/* hw/mac_pkg.sv */
`default_nettype none

package mac_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] pkt_addr_t;

    typedef enum logic [2:0] {
        op_read       = 3'd0,
        op_read_len   = 3'd1,
        op_read_next  = 3'd2,
        op_write      = 3'd3,
        op_write_len  = 3'd4,
        op_write_next = 3'd5
    } mac_op_e;

    typedef struct packed {
        mac_op_e   op;
        pkt_addr_t address;
        byte_t     value;
    } host_req_t;

    // fill side of a ring, write into the open slot, commit pushes it
    typedef struct packed {
        logic      write;
        logic      commit;
        pkt_addr_t addr;
        byte_t     data;
        pkt_addr_t len;
    } fill_req_t;

    typedef struct packed {
        pkt_addr_t addr;
        logic      release_slot; // frees the oldest slot
    } drain_req_t;

    typedef struct packed {
        byte_t data;
        logic  en;
        logic  er;
    } gmii_tx_t;

    typedef struct packed {
        byte_t data;
        logic  dv;
        logic  er;
    } gmii_rx_t;

    typedef enum logic [2:0] {tx_idle, tx_preamble, tx_sfd, tx_data, tx_fcs, tx_gap} tx_state_e;
    typedef enum logic [1:0] {rx_idle, rx_preamble, rx_data, rx_drop} rx_state_e;

    localparam byte_t preamble_byte = 8'h55;
    localparam byte_t sfd_byte      = 8'hd5;
    localparam int    preamble_len  = 7;
    localparam int    ifg_cycles    = 12;

    localparam logic [31:0] crc_init    = 32'hffff_ffff;
    localparam logic [31:0] crc_residue = 32'hdebb_20e3; // reflected form of c704dd7b

    localparam int default_ring_depth  = 4;
    localparam int default_packet_size = 64;

    // reflected crc-32, one byte per call, lsb first as on the wire
    function automatic logic [31:0] next_crc32(input byte_t data, input logic [31:0] crc);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ data[i]) ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
        return c;
    endfunction

endpackage

`default_nettype wire
